// ==== spim_macros.svh ====
// --------------------
// Width, depth and reset constants
// for the single-lane SPI master
// --------------------

`ifndef SPIM_MACROS_SVH
`define SPIM_MACROS_SVH

// Datapath
`define SPIM_DW        32   // Shift word and bus data width
`define SPIM_AW        3    // Register word address width

// FIFO depths
`define SPIM_CMD_DP    4    // Command entries
`define SPIM_RES_DP    4    // Response entries

// SPI clock generation
`define SPIM_DIV_W     8    // Divider register width
`define SPIM_DIV_RST   4    // Half period of 5 mclk out of reset

// Bit counter, wraps after one word
`define SPIM_BITCNT_W  5

`endif

// ==== spim_pkg.sv ====
// --------------------
// Shared types for the register map,
// command opcodes, command word and controller states
// --------------------

`default_nettype none

`include "spim_macros.svh"

package spim_pkg;

    // Register word addresses
    typedef enum logic [`SPIM_AW-1:0] {
        REG_CFG     = 3'd0,  // Divider read and write
        REG_STATUS  = 3'd1,  // Read-only FIFO flags and busy
        REG_TX      = 3'd2,  // Word pushed with CS kept low
        REG_TX_LAST = 3'd3,  // Word pushed then CS released
        REG_RX      = 3'd4   // Pop response
    } spim_reg_addr_e;

    // Command tag
    typedef enum logic {
        CMD_XFER      = 1'b0,
        CMD_XFER_LAST = 1'b1
    } spim_cmd_e;

    // Command FIFO entry with opcode on top
    typedef struct packed {
        spim_cmd_e             op;
        logic [`SPIM_DW-1:0]   data;
    } spim_cmd_word_t;

    // Controller FSM
    typedef enum logic [2:0] {
        CS_IDLE,     // Waiting for a command with CS high
        CS_SETUP,    // First bit on the line with CS low
        SHIFT_LOW,   // SPI clock low phase
        SHIFT_HIGH,  // SPI clock high phase
        PUSH_RES,    // Captured word into response FIFO
        CS_HOLD      // Burst open with CS held low
    } spim_ctrl_state_e;

endpackage

`default_nettype wire

// ==== spim_fifo.sv ====
// --------------------
// Synchronous FIFO
// Circular buffer with count, full/empty flags
// and head entry shown combinationally
// --------------------

`default_nettype none

module spim_fifo #(
    parameter int W  = 32,
    parameter int DP = 4
) (
    input  logic          mclk,
    input  logic          arst_n_i,
    input  logic          wr_en_i,
    input  logic [W-1:0]  wr_data_i,
    input  logic          rd_en_i,
    output logic [W-1:0]  rd_data_o,
    output logic          full_o,
    output logic          empty_o
);

    localparam int PTR_W = (DP > 1) ? $clog2(DP) : 1;
    localparam int CNT_W = $clog2(DP + 1);

    logic [W-1:0]     mem [DP];   // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;      // Entries held

    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en_i && !full_o;   // Guard against misuse
    assign do_rd = rd_en_i && !empty_o;

    assign full_o    = (count == CNT_W'(DP));
    assign empty_o   = (count == '0);
    assign rd_data_o = mem[rd_ptr];      // Head entry

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DP - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DP - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Producer and consumer must honour the flags
    a_no_overflow: assert property (@(posedge mclk) disable iff (!arst_n_i)
        wr_en_i |-> !full_o) else $error("FIFO write while full");
    a_no_underflow: assert property (@(posedge mclk) disable iff (!arst_n_i)
        rd_en_i |-> !empty_o) else $error("FIFO read while empty");

endmodule

`default_nettype wire

// ==== spim_regs.sv ====
// --------------------
// Wishbone register slave
// Divider config, status, command push,
// response pop, ack/err generation
// --------------------

`default_nettype none

`include "spim_macros.svh"

module spim_regs (
    input  logic                      mclk,
    input  logic                      arst_n_i,
    // Wishbone side
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [`SPIM_AW-1:0]       wb_adr_i,    // Word address
    input  logic [`SPIM_DW-1:0]       wb_dat_i,
    output logic [`SPIM_DW-1:0]       wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      wb_err_o,
    // Config
    output logic [`SPIM_DIV_W-1:0]    clk_div_o,
    // Command FIFO
    input  logic                      cmd_full_i,
    input  logic                      cmd_empty_i,
    output logic                      cmd_wr_o,
    output spim_pkg::spim_cmd_word_t  cmd_wdata_o,
    // Response FIFO
    input  logic                      res_full_i,
    input  logic                      res_empty_i,
    output logic                      res_rd_o,
    input  logic [`SPIM_DW-1:0]       res_rdata_i,
    // Controller
    input  logic                      busy_i
);

    spim_pkg::spim_reg_addr_e reg_addr;
    spim_pkg::spim_cmd_e      cmd_op;

    logic                req;        // New access this cycle
    logic                acc_err;
    logic                cfg_wr;
    logic [`SPIM_DW-1:0] rdata;

    assign reg_addr = spim_pkg::spim_reg_addr_e'(wb_adr_i);
    assign req      = wb_stb_i && !wb_ack_o;   // Strobe still high during ack cycle

    // Opcode comes from which TX register was hit
    assign cmd_op = (reg_addr == spim_pkg::REG_TX_LAST) ? spim_pkg::CMD_XFER_LAST
                                                         : spim_pkg::CMD_XFER;
    assign cmd_wdata_o = '{op: cmd_op, data: wb_dat_i};

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        acc_err  = 1'b0;
        cfg_wr   = 1'b0;
        cmd_wr_o = 1'b0;
        res_rd_o = 1'b0;
        rdata    = '0;
        if (req) begin
            case (reg_addr)
                spim_pkg::REG_CFG: begin
                    if (wb_we_i) cfg_wr = 1'b1;
                    else         rdata  = {{(`SPIM_DW-`SPIM_DIV_W){1'b0}}, clk_div_o};
                end
                spim_pkg::REG_STATUS: begin
                    rdata = {{(`SPIM_DW-5){1'b0}}, busy_i, res_full_i, res_empty_i,
                             cmd_full_i, cmd_empty_i};
                end
                spim_pkg::REG_TX, spim_pkg::REG_TX_LAST: begin
                    if (wb_we_i) begin
                        if (cmd_full_i) acc_err  = 1'b1;   // Refused, nothing queued
                        else            cmd_wr_o = 1'b1;
                    end
                end
                spim_pkg::REG_RX: begin
                    if (!wb_we_i) begin
                        if (res_empty_i) begin
                            acc_err = 1'b1;                // Underflow, data stays zero
                        end else begin
                            res_rd_o = 1'b1;
                            rdata    = res_rdata_i;        // Head entry
                        end
                    end
                end
                default: acc_err = 1'b1;                   // Unmapped
            endcase
        end
    end

    // --------------------
    // Response and config
    // --------------------
    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o  <= 1'b0;
            wb_err_o  <= 1'b0;
            clk_div_o <= `SPIM_DIV_W'(`SPIM_DIV_RST);
        end else begin
            wb_ack_o <= req;               // One cycle after stb
            wb_err_o <= req && acc_err;
            if (cfg_wr) begin
                clk_div_o <= wb_dat_i[`SPIM_DIV_W-1:0];
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (req) wb_dat_o <= rdata;        // Valid with ack
    end

    a_ack_pulse: assert property (@(posedge mclk) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o) else $error("Wishbone ack held two cycles");

endmodule

`default_nettype wire

// ==== spim_ctrl.sv ====
// --------------------
// SPI controller, mode 0, MSB first
// Chip-select FSM, half-period divider,
// shift out and capture of 32-bit words
// --------------------

`default_nettype none

`include "spim_macros.svh"

module spim_ctrl (
    input  logic                      mclk,
    input  logic                      arst_n_i,
    input  logic [`SPIM_DIV_W-1:0]    clk_div_i,     // Half period minus one
    // Command FIFO
    input  logic                      cmd_empty_i,
    output logic                      cmd_rd_o,
    input  spim_pkg::spim_cmd_word_t  cmd_rdata_i,
    // Response FIFO
    input  logic                      res_full_i,
    output logic                      res_wr_o,
    output logic [`SPIM_DW-1:0]       res_wdata_o,
    output logic                      busy_o,
    // Pads
    output logic                      spi_clk_o,
    output logic                      spi_csn_o,
    output logic                      spi_sdo_o,
    input  logic                      spi_sdi_i,
    output logic                      spi_oeb_o
);

    spim_pkg::spim_ctrl_state_e state_q;

    logic [`SPIM_DIV_W-1:0]    div_cnt;
    logic [`SPIM_BITCNT_W-1:0] bit_cnt;    // Falling edges seen, wraps at 32
    logic                      last_q;     // Current word releases CS
    logic [`SPIM_DW-1:0]       tx_q;       // Bits still to drive
    logic [`SPIM_DW-1:0]       rx_q;       // Captured bits

    logic timed;
    logic half_tick;
    logic rise;
    logic fall;

    // States that count half periods
    assign timed     = (state_q == spim_pkg::CS_SETUP) || (state_q == spim_pkg::SHIFT_LOW) ||
                       (state_q == spim_pkg::SHIFT_HIGH);
    assign half_tick = timed && (div_cnt == '0);

    // Clock edges on the pad
    assign rise = half_tick && ((state_q == spim_pkg::CS_SETUP) ||
                  ((state_q == spim_pkg::SHIFT_LOW) && (bit_cnt != '0)));
    assign fall = half_tick && (state_q == spim_pkg::SHIFT_HIGH);

    // Pop only with room for the answer
    assign cmd_rd_o = ((state_q == spim_pkg::CS_IDLE) || (state_q == spim_pkg::CS_HOLD)) &&
                      !cmd_empty_i && !res_full_i;

    assign res_wr_o    = (state_q == spim_pkg::PUSH_RES);
    assign res_wdata_o = rx_q;
    assign busy_o      = (state_q != spim_pkg::CS_IDLE);
    // Output enable follows the FSM, low while the slave is selected
    assign spi_oeb_o   = (state_q == spim_pkg::CS_IDLE) ||
                         ((state_q == spim_pkg::PUSH_RES) && last_q);

    // --------------------
    // Chip-select and shift FSM
    // --------------------
    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= spim_pkg::CS_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            last_q    <= 1'b0;
            spi_clk_o <= 1'b0;
            spi_csn_o <= 1'b1;
            spi_sdo_o <= 1'b0;
        end else begin
            if (cmd_rd_o || half_tick) begin
                div_cnt <= clk_div_i;              // Reload each half period
            end else if (timed) begin
                div_cnt <= div_cnt - 1'b1;
            end

            case (state_q)
                spim_pkg::CS_IDLE, spim_pkg::CS_HOLD: begin
                    if (cmd_rd_o) begin
                        state_q   <= spim_pkg::CS_SETUP;
                        spi_csn_o <= 1'b0;
                        spi_sdo_o <= cmd_rdata_i.data[`SPIM_DW-1];  // MSB ahead of first rise
                        last_q    <= (cmd_rdata_i.op == spim_pkg::CMD_XFER_LAST);
                        bit_cnt   <= '0;
                    end
                end
                spim_pkg::CS_SETUP: begin
                    if (half_tick) begin
                        spi_clk_o <= 1'b1;
                        state_q   <= spim_pkg::SHIFT_HIGH;
                    end
                end
                spim_pkg::SHIFT_HIGH: begin
                    if (half_tick) begin
                        spi_clk_o <= 1'b0;
                        spi_sdo_o <= tx_q[`SPIM_DW-1];   // Next bit on falling edge
                        bit_cnt   <= bit_cnt + 1'b1;
                        state_q   <= spim_pkg::SHIFT_LOW;
                    end
                end
                spim_pkg::SHIFT_LOW: begin
                    if (half_tick) begin
                        if (bit_cnt == '0) begin
                            // Word done, CS rises here for a last word
                            spi_csn_o <= last_q;
                            state_q   <= spim_pkg::PUSH_RES;
                        end else begin
                            spi_clk_o <= 1'b1;
                            state_q   <= spim_pkg::SHIFT_HIGH;
                        end
                    end
                end
                spim_pkg::PUSH_RES: begin
                    state_q <= last_q ? spim_pkg::CS_IDLE : spim_pkg::CS_HOLD;
                end
                default: state_q <= spim_pkg::CS_IDLE;
            endcase
        end
    end

    // --------------------
    // Data shifters
    // --------------------
    always_ff @(posedge mclk) begin
        if (cmd_rd_o) begin
            tx_q <= {cmd_rdata_i.data[`SPIM_DW-2:0], 1'b0};
        end else if (fall) begin
            tx_q <= {tx_q[`SPIM_DW-2:0], 1'b0};
        end
        if (rise) begin
            rx_q <= {rx_q[`SPIM_DW-2:0], spi_sdi_i};   // Sample on rising edge
        end
    end

    a_clk_in_cs: assert property (@(posedge mclk) disable iff (!arst_n_i)
        $changed(spi_clk_o) |-> !spi_csn_o) else $error("SPI clock moved with CS high");
    a_oeb_cs: assert property (@(posedge mclk) disable iff (!arst_n_i)
        spi_oeb_o == spi_csn_o) else $error("Output enable out of step with CS");

endmodule

`default_nettype wire

// ==== spim_top.sv ====
// --------------------
// SPI master top
// Register slave, command/response FIFOs
// and controller wired to the pads
// --------------------

`default_nettype none

`include "spim_macros.svh"

module spim_top (
    input  logic                  mclk,
    input  logic                  arst_n_i,
    // Wishbone
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`SPIM_AW-1:0]   wb_adr_i,
    input  logic [`SPIM_DW-1:0]   wb_dat_i,
    output logic [`SPIM_DW-1:0]   wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    // Pads
    output logic                  spi_clk_o,
    output logic                  spi_csn_o,
    output logic                  spi_sdo_o,
    input  logic                  spi_sdi_i,
    output logic                  spi_oeb_o
);

    logic [`SPIM_DIV_W-1:0]   clk_div;     // Half period config
    logic                     busy;        // Controller active

    // Command path
    logic                     cmd_full;
    logic                     cmd_empty;
    logic                     cmd_wr;
    logic                     cmd_rd;
    spim_pkg::spim_cmd_word_t cmd_wdata;
    spim_pkg::spim_cmd_word_t cmd_rdata;

    // Response path
    logic                     res_full;
    logic                     res_empty;
    logic                     res_wr;
    logic                     res_rd;
    logic [`SPIM_DW-1:0]      res_wdata;
    logic [`SPIM_DW-1:0]      res_rdata;

    spim_regs u_regs (
        .mclk        (mclk),
        .arst_n_i    (arst_n_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .clk_div_o   (clk_div),
        .cmd_full_i  (cmd_full),
        .cmd_empty_i (cmd_empty),
        .cmd_wr_o    (cmd_wr),
        .cmd_wdata_o (cmd_wdata),
        .res_full_i  (res_full),
        .res_empty_i (res_empty),
        .res_rd_o    (res_rd),
        .res_rdata_i (res_rdata),
        .busy_i      (busy)
    );

    // Opcode plus data word
    spim_fifo #(.W(`SPIM_DW + 1), .DP(`SPIM_CMD_DP)) u_cmd_fifo (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (cmd_wr),
        .wr_data_i (cmd_wdata),
        .rd_en_i   (cmd_rd),
        .rd_data_o (cmd_rdata),
        .full_o    (cmd_full),
        .empty_o   (cmd_empty)
    );

    spim_fifo #(.W(`SPIM_DW), .DP(`SPIM_RES_DP)) u_res_fifo (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (res_wr),
        .wr_data_i (res_wdata),
        .rd_en_i   (res_rd),
        .rd_data_o (res_rdata),
        .full_o    (res_full),
        .empty_o   (res_empty)
    );

    spim_ctrl u_ctrl (
        .mclk        (mclk),
        .arst_n_i    (arst_n_i),
        .clk_div_i   (clk_div),
        .cmd_empty_i (cmd_empty),
        .cmd_rd_o    (cmd_rd),
        .cmd_rdata_i (cmd_rdata),
        .res_full_i  (res_full),
        .res_wr_o    (res_wr),
        .res_wdata_o (res_wdata),
        .busy_o      (busy),
        .spi_clk_o   (spi_clk_o),
        .spi_csn_o   (spi_csn_o),
        .spi_sdo_o   (spi_sdo_o),
        .spi_sdi_i   (spi_sdi_i),
        .spi_oeb_o   (spi_oeb_o)
    );

endmodule

`default_nettype wire

// ==== tb_spim_top.sv ====
// --------------------
// Directed testbench for the SPI master top
// Loopback pad model, Wishbone access tasks,
// edge monitors and summary report
// --------------------

`default_nettype none

`include "spim_macros.svh"

module tb_spim_top;

    localparam int ACK_TIMEOUT    = 20;      // mclk cycles per bus access
    localparam int POLL_TIMEOUT   = 20000;   // Status reads
    localparam int CLK_TIMEOUT    = 1000;    // mclk cycles per SPI clock level
    localparam int STAT_CMD_FULL  = 1;
    localparam int STAT_RES_EMPTY = 2;
    localparam int STAT_RES_FULL  = 3;

    logic                 mclk;
    logic                 arst_n_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [`SPIM_AW-1:0]  wb_adr_i;
    logic [`SPIM_DW-1:0]  wb_dat_i;
    logic [`SPIM_DW-1:0]  wb_dat_o;
    logic                 wb_ack_o;
    logic                 wb_err_o;
    logic                 spi_clk_o;
    logic                 spi_csn_o;
    logic                 spi_sdo_o;
    logic                 spi_oeb_o;

    int          checks    = 0;
    int          errors    = 0;
    int          clk_edges = 0;   // Rising SPI clock edges inside a frame
    int          csn_rises = 0;
    logic [31:0] sent_q[$];       // Words expected back, in order

    // Slave model is a plain wire, sdo back into sdi
    spim_top dut (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .spi_clk_o (spi_clk_o),
        .spi_csn_o (spi_csn_o),
        .spi_sdo_o (spi_sdo_o),
        .spi_sdi_i (spi_sdo_o),
        .spi_oeb_o (spi_oeb_o)
    );

    // --------------------
    // Clock and monitors
    // --------------------
    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    always @(posedge spi_clk_o) begin
        if (!spi_csn_o) clk_edges++;
    end

    always @(posedge spi_csn_o) begin
        csn_rises++;                            // Frame releases
    end

    // --------------------
    // Check and bus tasks
    // --------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("At %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [`SPIM_AW-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int n;
        @(posedge mclk);
        #1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        rdata    = '0;
        err      = 1'b0;
        for (n = 0; n < ACK_TIMEOUT; n++) begin
            @(posedge mclk);
            #1;
            if (wb_ack_o) break;
        end
        check_true(wb_ack_o, "timeout, no Wishbone ack for the access");
        if (wb_ack_o) begin
            rdata = wb_dat_o;                   // Valid with ack
            err   = wb_err_o;
        end
        wb_stb_i = 1'b0;                        // Strobe drops after ack
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [`SPIM_AW-1:0] adr, input logic [31:0] data,
                            output logic err);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused, err);
    endtask

    task automatic wb_read(input logic [`SPIM_AW-1:0] adr, output logic [31:0] data,
                           output logic err);
        bus_cycle(1'b0, adr, '0, data, err);
    endtask

    task automatic wait_status(input int bit_idx, input logic level, input string what);
        logic [31:0] stat;
        logic        err;
        int          n;
        for (n = 0; n < POLL_TIMEOUT; n++) begin
            wb_read(spim_pkg::REG_STATUS, stat, err);
            if (stat[bit_idx] == level) break;
        end
        check_true(n < POLL_TIMEOUT, {"timeout waiting for ", what});
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished, %0d errors", name, errors - err_before);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_cfg();
        int          err0;
        logic [7:0]  div;
        logic [31:0] rd;
        logic        err;
        err0 = errors;
        check_value("spi_csn_o", 32'(spi_csn_o), 32'd1);
        check_value("spi_clk_o", 32'(spi_clk_o), 32'd0);
        check_value("spi_sdo_o", 32'(spi_sdo_o), 32'd0);
        check_value("spi_oeb_o", 32'(spi_oeb_o), 32'd1);
        check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
        check_value("wb_err_o", 32'(wb_err_o), 32'd0);
        wb_read(spim_pkg::REG_CFG, rd, err);
        check_value("divider after reset", rd, `SPIM_DIV_RST);
        div = 8'($urandom);
        wb_write(spim_pkg::REG_CFG, {24'd0, div}, err);
        wb_read(spim_pkg::REG_CFG, rd, err);
        check_value("divider readback", rd, {24'd0, div});
        wb_read(spim_pkg::REG_STATUS, rd, err);
        check_value("status", rd, 32'h5);       // Both FIFOs empty, idle
        wb_write(spim_pkg::REG_CFG, 32'd1, err);   // Short frames for later tests
        report_test("test_reset_cfg", err0);
    endtask

    task automatic test_single_word();
        int          err0;
        int          edges0;
        logic [31:0] word;
        logic [31:0] rd;
        logic        err;
        err0   = errors;
        edges0 = clk_edges;
        word   = $urandom;
        wb_write(spim_pkg::REG_TX_LAST, word, err);
        check_value("wb_err_o on push", 32'(err), 32'd0);
        wait_status(STAT_RES_EMPTY, 1'b0, "the response word");
        wb_read(spim_pkg::REG_RX, rd, err);
        check_value("rx word", rd, word);
        check_value("spi_clk_o rising edges", clk_edges - edges0, 32'd32);
        check_value("spi_csn_o after frame", 32'(spi_csn_o), 32'd1);
        report_test("test_single_word", err0);
    endtask

    task automatic test_burst();
        int                  err0;
        int                  edges0;
        int                  rises0;
        int                  i;
        logic [`SPIM_AW-1:0] adr;
        logic [31:0]         word;
        logic [31:0]         rd;
        logic                err;
        err0   = errors;
        edges0 = clk_edges;
        rises0 = csn_rises;
        sent_q.delete();
        for (i = 0; i < 4; i++) begin
            word = $urandom;
            adr  = (i == 3) ? spim_pkg::REG_TX_LAST : spim_pkg::REG_TX;
            sent_q.push_back(word);
            wb_write(adr, word, err);
        end
        wait_status(STAT_RES_FULL, 1'b1, "four burst responses");
        check_value("spi_clk_o rising edges", clk_edges - edges0, 32'd128);
        check_value("spi_csn_o rises in burst", csn_rises - rises0, 32'd1);   // Final only
        for (i = 0; i < 4; i++) begin
            wb_read(spim_pkg::REG_RX, rd, err);
            check_value("burst rx word", rd, sent_q[i]);
        end
        report_test("test_burst", err0);
    endtask

    task automatic test_errors();
        int          err0;
        int          i;
        int          refused;
        logic [31:0] word;
        logic [31:0] rd;
        logic        err;
        err0    = errors;
        refused = 0;
        wb_read(spim_pkg::REG_RX, rd, err);
        check_value("wb_err_o on empty pop", 32'(err), 32'd1);
        check_value("data on empty pop", rd, 32'd0);
        sent_q.delete();
        wb_write(spim_pkg::REG_CFG, 32'd255, err);   // Slow frames keep the FIFO full
        for (i = 0; i < `SPIM_CMD_DP + 2; i++) begin
            word = $urandom;
            wb_write(spim_pkg::REG_TX_LAST, word, err);
            if (err) refused++;
            else     sent_q.push_back(word);
        end
        // First word leaves the FIFO at once, so one more fits
        check_value("accepted writes", sent_q.size(), `SPIM_CMD_DP + 1);
        check_value("refused writes", refused, 32'd1);
        wb_read(spim_pkg::REG_STATUS, rd, err);
        check_value("status command full", 32'(rd[STAT_CMD_FULL]), 32'd1);
        wb_write(spim_pkg::REG_CFG, 32'd0, err);
        for (i = 0; i < sent_q.size(); i++) begin
            wait_status(STAT_RES_EMPTY, 1'b0, "a drained response");
            wb_read(spim_pkg::REG_RX, rd, err);
            check_value("drained rx word", rd, sent_q[i]);
        end
        report_test("test_errors", err0);
    endtask

    task automatic test_clk_div();
        int          err0;
        int          k;
        int          n;
        int          high;
        logic [31:0] div;
        logic [31:0] word;
        logic [31:0] rd;
        logic        err;
        err0 = errors;
        for (k = 0; k < 2; k++) begin
            div  = (k == 0) ? 32'd0 : 32'd3;
            word = $urandom;
            wb_write(spim_pkg::REG_CFG, div, err);
            wb_write(spim_pkg::REG_TX_LAST, word, err);
            for (n = 0; n < CLK_TIMEOUT && !spi_clk_o; n++) begin
                @(posedge mclk);
                #1;
            end
            check_true(spi_clk_o, "timeout waiting for spi_clk_o to rise");
            for (high = 0; high < CLK_TIMEOUT && spi_clk_o; high++) begin
                @(posedge mclk);
                #1;
            end
            check_value("spi_clk_o high cycles", high, div + 1);   // Half period
            wait_status(STAT_RES_EMPTY, 1'b0, "the response word");
            wb_read(spim_pkg::REG_RX, rd, err);
            check_value("rx word", rd, word);
        end
        report_test("test_clk_div", err0);
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        int seed_ret;
        seed_ret = $urandom(32'h4e9ea563);
        arst_n_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (10) @(posedge mclk);
        #1 arst_n_i = 1'b1;
        test_reset_cfg();
        test_single_word();
        test_burst();
        test_errors();
        test_clk_div();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
spim_pkg.sv
spim_fifo.sv
spim_regs.sv
spim_ctrl.sv
spim_top.sv
tb_spim_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the SPI master testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_spim_top -f compile.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "^ALL CHECKS PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
